// File: wvb_defines.svh
// --------------------------------------------------
// waveform buffer size macros
// address and word widths, event length,
// header FIFO depth and output link credits
// --------------------------------------------------
`ifndef WVB_DEFINES_SVH
`define WVB_DEFINES_SVH

// sample memory address width, depth is 2**width
`define WVB_ADR_WIDTH 10

// ADC sample and output link word width
`define WVB_DATA_WIDTH 16

// fixed number of samples per event
`define WVB_EVT_LEN 32

// number of queued event headers
`define WVB_HDR_DEPTH 8

// credits granted by the receiver after reset
`define WVB_CREDITS 4

`endif

// File: wvb_pkg.sv
// --------------------------------------------------
// waveform buffer types
// event header struct, header word union and the
// sample / output link word
// --------------------------------------------------
`include "wvb_defines.svh"

package wvb_pkg;

  // sample and link word
  typedef logic [`WVB_DATA_WIDTH-1:0] wvb_word_t;

  // event header, 48 bits, msb first on the link
  typedef struct packed {
    logic [23:0]                evt_ltc;
    logic [`WVB_ADR_WIDTH-1:0]  start_addr;
    // last address written for the event
    logic [`WVB_ADR_WIDTH-1:0]  stop_addr;
    logic [3:0]                 trig_src;
  } wvb_hdr_t;

  // raw view is what the FIFO stores and the reader slices
  typedef union packed {
    wvb_hdr_t     f;
    logic [47:0]  raw;
  } wvb_hdr_u;

endpackage

// File: wvb_hdr_if.sv
// --------------------------------------------------
// header FIFO interface
// writer, FIFO, reader and overflow monitor views
// --------------------------------------------------
interface wvb_hdr_if;
  import wvb_pkg::*;

  logic      push;
  wvb_hdr_u  push_hdr;
  logic      full;
  logic      pop;
  wvb_hdr_u  head_hdr;
  // head entry is valid while empty is low
  logic      empty;

  modport writer (output push, output push_hdr);

  modport fifo (
    input  push, push_hdr, pop,
    output full, head_hdr, empty
  );

  modport reader (output pop, input head_hdr, empty);

  modport monitor (input full, pop, head_hdr);

endinterface

// File: wvb_sample_ram.sv
// --------------------------------------------------
// circular sample memory
// one write port, one read port with a registered
// output (1 cycle read latency)
// --------------------------------------------------
`include "wvb_defines.svh"

module wvb_sample_ram (
  input  logic                       clk,
  input  logic                       wr_en,
  input  logic [`WVB_ADR_WIDTH-1:0]  wr_addr,
  input  wvb_pkg::wvb_word_t         wr_data,
  input  logic [`WVB_ADR_WIDTH-1:0]  rd_addr,
  output wvb_pkg::wvb_word_t         rd_data
);
  import wvb_pkg::*;

  localparam int DEPTH = 1 << `WVB_ADR_WIDTH;

  wvb_word_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // read data follows rd_addr by one edge
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// File: wvb_writer.sv
// --------------------------------------------------
// waveform buffer writer
// trigger acceptance, write address sequencing and
// event header construction
// --------------------------------------------------
`include "wvb_defines.svh"

module wvb_writer (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       trig,
  input  logic [3:0]                 trig_src,
  input  logic [23:0]                ltc,
  input  wvb_pkg::wvb_word_t         adc_data,
  input  logic                       overflow,
  input  logic [`WVB_ADR_WIDTH-1:0]  wused,
  output logic                       wr_en,
  output logic [`WVB_ADR_WIDTH-1:0]  wr_addr,
  output wvb_pkg::wvb_word_t         wr_data,
  wvb_hdr_if.writer                  hdr
);

  localparam int CNT_W    = $clog2(`WVB_EVT_LEN);
  // room for a full event plus the overflow guard word
  localparam int MAX_USED = (1 << `WVB_ADR_WIDTH) - `WVB_EVT_LEN - 1;

  logic                       busy;
  logic [CNT_W-1:0]           cnt;
  logic                       accept;
  logic                       last;

  // captured at trigger acceptance
  logic [23:0]                ltc_q;
  logic [3:0]                 src_q;
  logic [`WVB_ADR_WIDTH-1:0]  start_q;

  assign accept = trig && !busy && !overflow && (int'(wused) <= MAX_USED);
  assign last   = busy && (cnt == CNT_W'(`WVB_EVT_LEN - 1));

  // first sample goes in on the acceptance edge itself
  assign wr_en   = accept || busy;
  assign wr_data = adc_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy    <= 1'b0;
      cnt     <= '0;
      wr_addr <= '0;
    end else begin
      if (wr_en) begin
        // address wraps and carries over to the next event
        wr_addr <= wr_addr + 1'b1;
      end
      if (accept) begin
        busy <= 1'b1;
        cnt  <= CNT_W'(1);
      end else if (last) begin
        busy <= 1'b0;
      end else if (busy) begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      ltc_q   <= ltc;
      src_q   <= trig_src;
      start_q <= wr_addr;
    end
  end

  // header goes out with the last sample write
  assign hdr.push = last;

  always_comb begin
    hdr.push_hdr.f.evt_ltc    = ltc_q;
    hdr.push_hdr.f.start_addr = start_q;
    hdr.push_hdr.f.stop_addr  = wr_addr;
    hdr.push_hdr.f.trig_src   = src_q;
  end

endmodule

// File: wvb_hdr_fifo.sv
// --------------------------------------------------
// event header FIFO
// first-word-fall-through queue of raw header words
// with full and empty flags
// --------------------------------------------------
`include "wvb_defines.svh"

module wvb_hdr_fifo (
  input  logic  clk,
  input  logic  rst,
  wvb_hdr_if.fifo hdr
);
  import wvb_pkg::*;

  localparam int PW = $clog2(`WVB_HDR_DEPTH);

  wvb_hdr_u        mem [`WVB_HDR_DEPTH];
  logic [PW-1:0]   wr_ptr;
  logic [PW-1:0]   rd_ptr;
  logic [PW:0]     count;
  logic            do_push;
  logic            do_pop;

  assign do_push = hdr.push && !hdr.full;
  assign do_pop  = hdr.pop && !hdr.empty;

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= hdr.push_hdr;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign hdr.full     = (count == (PW+1)'(`WVB_HDR_DEPTH));
  assign hdr.empty    = (count == '0);
  assign hdr.head_hdr = mem[rd_ptr];

endmodule

// File: wvb_overflow_ctrl.sv
// --------------------------------------------------
// waveform buffer overflow controller
// last address read, overflow flag and words used
// --------------------------------------------------
`include "wvb_defines.svh"

module wvb_overflow_ctrl (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [`WVB_ADR_WIDTH-1:0]  wr_addr,
  input  logic                       rd_done,
  wvb_hdr_if.monitor                 hdr,
  output logic                       overflow,
  output logic [`WVB_ADR_WIDTH-1:0]  wused
);

  logic [`WVB_ADR_WIDTH-1:0]  last_rd_addr;
  logic [`WVB_ADR_WIDTH-1:0]  stop_q;
  logic                       rd_done_q;

  // head moves on at the pop, so grab stop_addr there
  always_ff @(posedge clk) begin
    if (hdr.pop) begin
      stop_q <= hdr.head_hdr.f.stop_addr;
    end
  end

  // all ones after reset, so address 0 is the next one to read
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_done_q    <= 1'b0;
      last_rd_addr <= '1;
    end else begin
      rd_done_q <= rd_done;
      if (rd_done_q) begin
        last_rd_addr <= stop_q;
      end
    end
  end

  // writer caught up with the reader, or no header slot left
  assign overflow = hdr.full || (wr_addr == last_rd_addr);

  // distance from the next address to read up to the write pointer
  assign wused = wr_addr - (last_rd_addr + 1'b1);

endmodule

// File: wvb_reader.sv
// --------------------------------------------------
// waveform buffer reader
// sends three header words then the event samples
// over a credit based output link
// --------------------------------------------------
`include "wvb_defines.svh"

module wvb_reader (
  input  logic                       clk,
  input  logic                       rst,
  wvb_hdr_if.reader                  hdr,
  output logic [`WVB_ADR_WIDTH-1:0]  rd_addr,
  input  wvb_pkg::wvb_word_t         rd_data,
  output logic                       rd_done,
  output logic                       out_valid,
  output wvb_pkg::wvb_word_t         out_data,
  output logic                       out_last,
  input  logic                       credit
);

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_HDR  = 2'd1;
  localparam logic [1:0] S_DATA = 2'd2;

  localparam int CW = $clog2(`WVB_CREDITS + 1);

  logic [1:0]                 state;
  logic [1:0]                 idx;
  logic [`WVB_ADR_WIDTH-1:0]  ptr;
  logic [CW-1:0]              credits;
  logic                       is_last;
  logic                       advance;

  // one word per cycle while credits remain
  assign out_valid = (state != S_IDLE) && (credits != '0);
  assign is_last   = (state == S_DATA) && (ptr == hdr.head_hdr.f.stop_addr);
  assign out_last  = out_valid && is_last;
  assign advance   = out_valid && (state == S_DATA) && !is_last;

  // look one address ahead when moving on, so rd_data always holds mem[ptr]
  assign rd_addr = advance ? ptr + 1'b1 : ptr;

  always_comb begin
    if (state == S_DATA) begin
      out_data = rd_data;
    end else begin
      case (idx)
        2'd0:    out_data = hdr.head_hdr.raw[47:32];
        2'd1:    out_data = hdr.head_hdr.raw[31:16];
        default: out_data = hdr.head_hdr.raw[15:0];
      endcase
    end
  end

  // event fully sent, release the header and the memory
  assign hdr.pop = out_last;
  assign rd_done = out_last;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= S_IDLE;
      idx   <= '0;
      ptr   <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (!hdr.empty) begin
            state <= S_HDR;
            idx   <= '0;
            ptr   <= hdr.head_hdr.f.start_addr;
          end
        end
        S_HDR: begin
          if (out_valid) begin
            if (idx == 2'd2) begin
              state <= S_DATA;
            end else begin
              idx <= idx + 1'b1;
            end
          end
        end
        S_DATA: begin
          if (out_last) begin
            state <= S_IDLE;
          end else if (advance) begin
            ptr <= ptr + 1'b1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // credit returned and word sent in one cycle cancel out
  always_ff @(posedge clk) begin
    if (rst) begin
      credits <= CW'(`WVB_CREDITS);
    end else begin
      case ({credit, out_valid})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;
      endcase
    end
  end

endmodule

// File: wvb_top.sv
// --------------------------------------------------
// waveform buffer top level
// writer, sample memory, header FIFO, reader and
// overflow controller
// --------------------------------------------------
`include "wvb_defines.svh"

module wvb_top (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       trig,
  input  logic [3:0]                 trig_src,
  input  logic [23:0]                ltc,
  input  wvb_pkg::wvb_word_t         adc_data,
  input  logic                       credit,
  output logic                       out_valid,
  output wvb_pkg::wvb_word_t         out_data,
  output logic                       out_last,
  output logic                       overflow,
  output logic [`WVB_ADR_WIDTH-1:0]  wused
);
  import wvb_pkg::*;

  logic                       wr_en;
  logic [`WVB_ADR_WIDTH-1:0]  wr_addr;
  wvb_word_t                  wr_data;
  logic [`WVB_ADR_WIDTH-1:0]  rd_addr;
  wvb_word_t                  rd_data;
  logic                       rd_done;

  wvb_hdr_if hdr ();

  wvb_writer u_writer (
    .clk      (clk),
    .rst      (rst),
    .trig     (trig),
    .trig_src (trig_src),
    .ltc      (ltc),
    .adc_data (adc_data),
    .overflow (overflow),
    .wused    (wused),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .hdr      (hdr)
  );

  wvb_sample_ram u_ram (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  wvb_hdr_fifo u_fifo (
    .clk (clk),
    .rst (rst),
    .hdr (hdr)
  );

  wvb_reader u_reader (
    .clk       (clk),
    .rst       (rst),
    .hdr       (hdr),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .rd_done   (rd_done),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_last  (out_last),
    .credit    (credit)
  );

  wvb_overflow_ctrl u_ovfl (
    .clk      (clk),
    .rst      (rst),
    .wr_addr  (wr_addr),
    .rd_done  (rd_done),
    .hdr      (hdr),
    .overflow (overflow),
    .wused    (wused)
  );

endmodule

// File: tb_wvb.sv
// --------------------------------------------------
// waveform buffer testbench
// stimulus, credit receiver, reference model,
// assertions, watchdog and final report
// --------------------------------------------------
`include "wvb_defines.svh"

module tb_wvb;
  timeunit 1ns;
  timeprecision 100ps;
  import wvb_pkg::*;

  localparam int CLK_PERIOD   = 4;
  localparam int N_RAND       = 60;
  localparam int N_STALL      = 56;
  localparam int STALL_FACTOR = 8;
  localparam int WD_CYCLES    = (N_RAND + N_STALL) * (`WVB_EVT_LEN + 3) * STALL_FACTOR;
  localparam int LAST_POS     = `WVB_EVT_LEN + 2;
  localparam int MAX_USED     = (1 << `WVB_ADR_WIDTH) - `WVB_EVT_LEN - 1;

  logic clk = 1'b0;
  logic rst, trig, credit;
  logic [3:0] trig_src;
  logic [23:0] ltc;
  wvb_word_t adc_data;
  logic out_valid, out_last, overflow;
  wvb_word_t out_data;
  logic [`WVB_ADR_WIDTH-1:0] wused;

  // reference model state
  logic [`WVB_ADR_WIDTH-1:0] m_wr_addr, m_last_rd, m_pend_addr, m_wused;
  logic m_busy, m_pend, m_overflow, m_accept, exp_avail;
  int m_cnt, m_events, m_credits, word_pos;
  wvb_word_t exp_word;
  wvb_word_t exp_q[$];
  wvb_word_t cur_q[$];
  logic [`WVB_ADR_WIDTH-1:0] stop_addrs[$];
  wvb_hdr_u cur_hdr;

  int errors = 0;
  int offered = 0;
  int accepted = 0;
  int done_events = 0;
  logic seen_full = 1'b0;
  int credit_mode = 0;
  int stall_left = 0;

  wvb_top uut (
    .clk(clk), .rst(rst), .trig(trig), .trig_src(trig_src), .ltc(ltc),
    .adc_data(adc_data), .credit(credit), .out_valid(out_valid),
    .out_data(out_data), .out_last(out_last), .overflow(overflow), .wused(wused)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic report_mismatch(input string sig, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    errors++;
    $display("[ERROR] %0t ns %s expected %0h got %0h", $time, sig, exp_v, act_v);
  endtask

  task automatic note_failure(input string msg);
    errors++;
    $display("%0t ns: %s", $time, msg);
  endtask

  task automatic print_counts();
    $display("triggers offered %0d accepted %0d events read %0d errors %0d",
             offered, accepted, done_events, errors);
  endtask

  // one clock of stimulus driven just after the rising edge
  task automatic drive_cycle(input logic t);
    @(posedge clk);
    #1;
    ltc      = ltc + 1'b1;
    adc_data = wvb_word_t'($urandom);
    trig     = t;
    trig_src = 4'($urandom);
    if (stall_left > 0) begin
      stall_left--;
      credit = 1'b0;
    end else if (credit_mode == 1 && $urandom_range(0, 99) == 0) begin
      // receiver goes quiet for a while
      stall_left = $urandom_range(20, 150);
      credit     = 1'b0;
    end else begin
      credit = (m_credits < `WVB_CREDITS) &&
               (credit_mode == 2 || (credit_mode == 1 && $urandom_range(0, 1) == 1));
    end
  endtask

  assign m_overflow = (m_events == `WVB_HDR_DEPTH) || (m_wr_addr == m_last_rd);
  assign m_wused    = m_wr_addr - m_last_rd - 1'b1;
  assign m_accept   = trig && !m_busy && !m_overflow && (int'(m_wused) <= MAX_USED);

  always @(posedge clk) begin : model
    int pops;
    int pushes;
    logic [`WVB_ADR_WIDTH-1:0] freed;
    pops   = 0;
    pushes = 0;
    freed  = '0;
    if (rst) begin
      m_wr_addr <= '0;
      m_last_rd <= '1;
      m_busy    <= 1'b0;
      m_cnt     <= 0;
      m_events  <= 0;
      m_pend    <= 1'b0;
      m_credits <= `WVB_CREDITS;
      word_pos  <= 0;
      exp_avail <= 1'b0;
      exp_word  <= '0;
      exp_q.delete();
      cur_q.delete();
      stop_addrs.delete();
    end else begin
      if (trig) offered <= offered + 1;
      // one word leaves the link per valid cycle
      if (out_valid) begin
        if (exp_q.size() > 0) void'(exp_q.pop_front());
        if (word_pos == LAST_POS) begin
          word_pos <= 0;
          pops = 1;
          done_events <= done_events + 1;
          if (stop_addrs.size() > 0) freed = stop_addrs.pop_front();
        end else begin
          word_pos <= word_pos + 1;
        end
      end
      // write side
      if (m_accept) begin
        accepted <= accepted + 1;
        cur_hdr.f.evt_ltc    = ltc;
        cur_hdr.f.trig_src   = trig_src;
        cur_hdr.f.start_addr = m_wr_addr;
        cur_hdr.f.stop_addr  = m_wr_addr + (`WVB_EVT_LEN - 1);
        cur_q.delete();
        m_busy <= 1'b1;
        m_cnt  <= 1;
      end else if (m_busy && m_cnt == `WVB_EVT_LEN - 1) begin
        m_busy <= 1'b0;
        pushes = 1;
      end else if (m_busy) begin
        m_cnt <= m_cnt + 1;
      end
      if (m_accept || m_busy) begin
        cur_q.push_back(adc_data);
        m_wr_addr <= m_wr_addr + 1'b1;
      end
      if (pushes == 1) begin
        exp_q.push_back(cur_hdr.raw[47:32]);
        exp_q.push_back(cur_hdr.raw[31:16]);
        exp_q.push_back(cur_hdr.raw[15:0]);
        foreach (cur_q[i]) exp_q.push_back(cur_q[i]);
        stop_addrs.push_back(cur_hdr.f.stop_addr);
      end
      // memory is released one edge after the last word
      m_pend      <= (pops == 1);
      m_pend_addr <= freed;
      if (m_pend) m_last_rd <= m_pend_addr;
      m_events  <= m_events + pushes - pops;
      m_credits <= m_credits + int'(credit) - int'(out_valid);
      if (m_events == `WVB_HDR_DEPTH) seen_full <= 1'b1;
      exp_avail <= (exp_q.size() > 0);
      exp_word  <= (exp_q.size() > 0) ? exp_q[0] : '0;
    end
  end

  a_reset: assert property (@(posedge clk) $fell(rst) |->
      (!out_valid && !out_last && !overflow && wused == '0))
    else report_mismatch("out_valid/out_last/overflow/wused", 0,
      {$sampled(out_valid), $sampled(out_last), $sampled(overflow), $sampled(wused)});
  a_avail: assert property (@(posedge clk) disable iff (rst) out_valid |-> exp_avail)
    else note_failure("word sent on the link while no event was expected");
  a_hdr: assert property (@(posedge clk) disable iff (rst)
      (out_valid && exp_avail && word_pos < 3) |-> out_data == exp_word)
    else report_mismatch("out_data (header)", $sampled(exp_word), $sampled(out_data));
  a_smp: assert property (@(posedge clk) disable iff (rst)
      (out_valid && exp_avail && word_pos >= 3) |-> out_data == exp_word)
    else report_mismatch("out_data (sample)", $sampled(exp_word), $sampled(out_data));
  a_last: assert property (@(posedge clk) disable iff (rst)
      out_last == (out_valid && word_pos == LAST_POS))
    else report_mismatch("out_last", $sampled(out_valid && word_pos == LAST_POS),
      $sampled(out_last));
  a_credit: assert property (@(posedge clk) disable iff (rst) out_valid |-> m_credits > 0)
    else report_mismatch("out_valid", 0, $sampled(out_valid));
  a_ovf: assert property (@(posedge clk) disable iff (rst) overflow == m_overflow)
    else report_mismatch("overflow", $sampled(m_overflow), $sampled(overflow));
  a_wused: assert property (@(posedge clk) disable iff (rst) wused == m_wused)
    else report_mismatch("wused", $sampled(m_wused), $sampled(wused));

  initial begin : watchdog
    #(WD_CYCLES * CLK_PERIOD);
    note_failure("watchdog expired before all events were read back");
    print_counts();
    $display("Test FAILED");
    $finish;
  end

  initial begin : stimulus
    rst      = 1'b1;
    trig     = 1'b0;
    trig_src = '0;
    ltc      = '0;
    adc_data = '0;
    credit   = 1'b0;
    void'($urandom(32'habdf456e));
    repeat (5) drive_cycle(1'b0);
    rst = 1'b0;

    // random triggers and credits with occasional long stalls
    credit_mode = 1;
    repeat (N_RAND) begin
      repeat ($urandom_range(0, 47)) drive_cycle(1'b0);
      drive_cycle(1'b1);
    end

    // keep triggering without credits until the header FIFO is full
    credit_mode = 0;
    repeat (N_STALL) begin
      repeat ($urandom_range(0, 15)) drive_cycle(1'b0);
      drive_cycle(1'b1);
    end
    if (!seen_full) note_failure("header FIFO never filled during the credit stall");

    // everything queued has to come out once credits return
    credit_mode = 2;
    while (done_events != accepted || m_busy || m_pend || m_wused != '0) begin
      drive_cycle(1'b0);
    end
    drive_cycle(1'b0);
    assert (wused == '0) else report_mismatch("wused", 0, wused);
    assert (!overflow) else report_mismatch("overflow", 0, overflow);

    print_counts();
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+.
wvb_pkg.sv
wvb_hdr_if.sv
wvb_sample_ram.sv
wvb_writer.sv
wvb_hdr_fifo.sv
wvb_overflow_ctrl.sv
wvb_reader.sv
wvb_top.sv
tb_wvb.sv

// File: Bender.yml
package:
  name: wvb

sources:
  - include_dirs:
      - .
    files:
      - wvb_pkg.sv
      - wvb_hdr_if.sv
      - wvb_sample_ram.sv
      - wvb_writer.sv
      - wvb_hdr_fifo.sv
      - wvb_overflow_ctrl.sv
      - wvb_reader.sv
      - wvb_top.sv
      - target: test
        files:
          - tb_wvb.sv
